// ==== bench/execCoreTb.sv ====
`timescale 1ns/1ns

module execCoreTb;

    import rvPkg::*;

    ////////////////////////////////////////////////////////////
    // Run length and watchdog budget
    ////////////////////////////////////////////////////////////

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 5;
    localparam int randomOps   = 200;
    localparam int chainOps    = 20;
    localparam int idleOps     = 10;

    // Cycles per test including readbacks and trailing idles
    localparam int testCycles = resetCycles
        + (numRegs + 1)
        + 3
        + 30
        + (chainOps + 2)
        + (idleOps + numRegs + 1)
        + (randomOps + numRegs + 1);
    localparam int marginCycles = 50;
    localparam int timeoutNs    = (testCycles + marginCycles) * clkPeriod;

    logic     clk;
    logic     rst;
    logic     opValid;
    execOp_t  op;
    logic     wbValid;
    wbBus_t   wb;

    // Reference copy of the architectural registers
    word_t    model [numRegs];
    string    curTest;

    rvExecCore rvExecCore_inst (
        .clk     (clk),
        .rst     (rst),
        .opValid (opValid),
        .op      (op),
        .wbValid (wbValid),
        .wb      (wb)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Failure report and expected values
    ////////////////////////////////////////////////////////////

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // Expected ALU result from the RV32I rules
    function automatic word_t refAlu(input aluOp_t f, input word_t a, input word_t b);
        int    sh;
        word_t r;
        sh = int'(b & 32'h1f);
        r  = a;
        case (f)
            AluAdd: r = a + b;
            // Two's complement negate then add
            AluSub: r = a + (~b) + 32'd1;
            AluAnd: r = a & b;
            AluOr:  r = a | b;
            AluXor: r = a ^ b;
            AluSll: begin
                for (int i = 0; i < sh; i++) r = {r[xlen-2:0], 1'b0};
            end
            AluSrl: begin
                for (int i = 0; i < sh; i++) r = {1'b0, r[xlen-1:1]};
            end
            AluSra: begin
                for (int i = 0; i < sh; i++) r = {r[xlen-1], r[xlen-1:1]};
            end
            // Sign bits differ, so the negative one is smaller
            AluSlt: begin
                if (a[xlen-1] != b[xlen-1]) r = {31'd0, a[xlen-1]};
                else r = {31'd0, (a < b)};
            end
            AluSltu: r = (a < b) ? 32'd1 : 32'd0;
            default: r = '0;
        endcase
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Drive helpers
    ////////////////////////////////////////////////////////////

    // Issue one op, then check its report a cycle later
    task automatic doOp(input aluOp_t f, input regIdx_t rs1, input regIdx_t rs2,
                        input regIdx_t rd, input logic useImm, input word_t imm);
        execOp_t o;
        word_t   b;
        word_t   expData;
        o.aluOp  = f;
        o.rs1    = rs1;
        o.rs2    = rs2;
        o.rd     = rd;
        o.useImm = useImm;
        o.imm    = imm;
        b        = useImm ? imm : model[rs2];
        expData  = refAlu(f, model[rs1], b);
        // x0 keeps zero in the model too
        if (rd != 0) model[rd] = expData;
        opValid = 1'b1;
        op      = o;
        @(posedge clk);
        #1;
        assert (wbValid === 1'b1) else
            abortRun($sformatf("wbValid missing one cycle after issue in %s", curTest));
        assert (wb.rd === rd) else
            abortRun($sformatf("ERROR %s wb.rd expected %0d actual %0d",
                               curTest, rd, wb.rd));
        assert (wb.data === expData) else
            abortRun($sformatf("ERROR %s wb.data expected %h actual %h",
                               curTest, expData, wb.data));
    endtask

    // Idle cycle with junk on the op bus
    task automatic idleCycle();
        execOp_t o;
        o        = execOp_t'({$urandom, $urandom});
        opValid  = 1'b0;
        op       = o;
        @(posedge clk);
        #1;
        assert (wbValid === 1'b0) else
            abortRun($sformatf("wbValid raised with no op issued in %s", curTest));
    endtask

    task automatic loadImm(input regIdx_t rd, input word_t value);
        doOp(AluAdd, 0, 0, rd, 1'b1, value);
    endtask

    // Or with x0 reports the register through wb
    task automatic readAll();
        for (int k = 0; k < numRegs; k++) doOp(AluOr, regIdx_t'(k), 0, 0, 1'b0, '0);
        idleCycle();
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic resetClearsRegs();
        curTest = "resetClear";
        readAll();
    endtask

    task automatic x0StaysZero();
        curTest = "x0Zero";
        loadImm(0, 32'h12345678);
        doOp(AluOr, 0, 0, 0, 1'b0, '0);
        idleCycle();
    endtask

    task automatic runAluOps();
        curTest = "aluOps";
        loadImm(1, 32'h80000000);
        loadImm(2, 32'h00000001);
        loadImm(3, 32'hf0f0f0f0);
        loadImm(4, 32'd31);
        loadImm(5, 32'd0);
        loadImm(6, 32'h000000ff);
        doOp(AluAdd, 3, 2, 7, 1'b0, '0);
        // Wrap below zero and below the most negative value
        doOp(AluSub, 5, 2, 8, 1'b0, '0);
        doOp(AluSub, 1, 2, 9, 1'b0, '0);
        doOp(AluAnd, 3, 6, 10, 1'b0, '0);
        doOp(AluOr,  3, 6, 11, 1'b0, '0);
        doOp(AluXor, 3, 6, 12, 1'b0, '0);
        // Shift amounts 0 and 31
        doOp(AluSll, 3, 5, 13, 1'b0, '0);
        doOp(AluSll, 2, 4, 14, 1'b0, '0);
        doOp(AluSrl, 1, 4, 15, 1'b0, '0);
        doOp(AluSrl, 3, 5, 16, 1'b0, '0);
        // Negative value copies its sign
        doOp(AluSra, 3, 0, 17, 1'b1, 32'h00000004);
        doOp(AluSra, 1, 4, 18, 1'b0, '0);
        // Only the low five bits of the amount count
        doOp(AluSra, 3, 0, 19, 1'b1, 32'hffffffe4);
        // 0x80000000 signed against unsigned
        doOp(AluSlt,  1, 2, 20, 1'b0, '0);
        doOp(AluSltu, 1, 2, 21, 1'b0, '0);
        doOp(AluSlt,  2, 1, 22, 1'b0, '0);
        doOp(AluSltu, 2, 1, 23, 1'b0, '0);
        doOp(AluSlt,  3, 0, 24, 1'b1, 32'hffffffff);
        doOp(AluSltu, 3, 0, 25, 1'b1, 32'hffffffff);
        idleCycle();
    endtask

    task automatic runDepChain();
        aluOp_t  chainList [5] = '{AluAdd, AluXor, AluSub, AluSll, AluOr};
        regIdx_t prevRd;
        regIdx_t nextRd;
        curTest = "depChain";
        loadImm(10, 32'd3);
        prevRd = 10;
        // Every op reads the rd written the cycle before
        for (int i = 0; i < chainOps; i++) begin
            nextRd = regIdx_t'(11 + (i % 5));
            doOp(chainList[i % 5], prevRd, prevRd, nextRd, 1'($urandom), $urandom);
            prevRd = nextRd;
        end
        idleCycle();
    endtask

    task automatic idleKeepsState();
        curTest = "idleCycles";
        for (int i = 0; i < idleOps; i++) idleCycle();
        readAll();
    endtask

    task automatic runRandomStream();
        aluOp_t f;
        curTest = "randomStream";
        for (int i = 0; i < randomOps; i++) begin
            f = aluOp_t'($urandom_range(9, 0));
            doOp(f, regIdx_t'($urandom), regIdx_t'($urandom), regIdx_t'($urandom),
                 1'($urandom), $urandom);
        end
        readAll();
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        #(timeoutNs);
        abortRun("Timeout, the tests ran longer than their expected length");
    end

    initial begin
        void'($urandom(32'h81ab7744));
        clk       = 1'b0;
        rst       = 1'b1;
        opValid   = 1'b0;
        op        = '0;
        curTest   = "reset";
        for (int k = 0; k < numRegs; k++) model[k] = '0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (wbValid === 1'b0) else abortRun("wbValid is not low after reset");
        assert (wb === '0) else abortRun("wb contents are not zero after reset");
        resetClearsRegs();
        x0StaysZero();
        runAluOps();
        runDepChain();
        idleKeepsState();
        runRandomStream();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== hw/regCell.sv ====
`timescale 1ns/1ns

// Single architectural register
// Gates its value onto each read port only when addressed
module regCell #(
    // Register number this cell answers to
    parameter int unsigned cellIndex = 0
) (
    input  logic           clk,
    input  logic           rst,
    // Load strobe from the write decoder
    input  logic           en,
    // Shared write data
    input  rvPkg::word_t   d,
    // Read addresses for both ports
    input  rvPkg::regIdx_t rs1,
    input  rvPkg::regIdx_t rs2,
    // Gated words, zero when not selected
    output rvPkg::word_t   q1,
    output rvPkg::word_t   q2
);

    import rvPkg::*;

    // Own index at register index width
    localparam regIdx_t myIdx = regIdx_t'(cellIndex);

    // Stored word
    word_t value;

    // Clears on reset, loads on enable
    always_ff @(posedge clk) begin
        if (rst) begin
            value <= '0;
        end else if (en) begin
            value <= d;
        end
    end

    // Zero when unselected so the combiner can just OR
    assign q1 = (rs1 == myIdx) ? value : '0;
    assign q2 = (rs2 == myIdx) ? value : '0;

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ns

// Two-read one-write integer register file
// Reads are combinational, writes land on the rising edge
module regFile (
    input  logic           clk,
    input  logic           rst,
    // Read port 1
    input  rvPkg::regIdx_t rs1,
    output rvPkg::word_t   rs1Data,
    // Read port 2
    input  rvPkg::regIdx_t rs2,
    output rvPkg::word_t   rs2Data,
    // Write port
    input  logic           wEn,
    input  rvPkg::regIdx_t wSel,
    input  rvPkg::word_t   wData
);

    import rvPkg::*;

    // Per-cell load enables
    logic [numRegs-1:0] cellEn;

    // Gated cell words for each read port
    word_t cellQ1 [numRegs];
    word_t cellQ2 [numRegs];

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    regWriteDecode writeDecodeInst (
        .wEn    (wEn),
        .wSel   (wSel),
        .cellEn (cellEn)
    );

    ////////////////////////////////////////////////////////////
    // Storage cells
    ////////////////////////////////////////////////////////////

    // One cell per architectural register
    // Cell 0 exists but its enable is tied low
    for (genvar i = 0; i < numRegs; i++) begin : gCell
        regCell #(
            .cellIndex (i)
        ) cellInst (
            .clk (clk),
            .rst (rst),
            .en  (cellEn[i]),
            .d   (wData),
            .rs1 (rs1),
            .rs2 (rs2),
            .q1  (cellQ1[i]),
            .q2  (cellQ2[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////

    // No bypass needed since writes settle before the next read
    regReadPorts readPortsInst (
        .cellQ1  (cellQ1),
        .cellQ2  (cellQ2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

endmodule

// ==== hw/regReadPorts.sv ====
`timescale 1ns/1ns

// Read-port combiner
// Merges the gated words of all cells into one word per port
module regReadPorts (
    // Port 1 gated words, one per cell
    input  rvPkg::word_t cellQ1 [rvPkg::numRegs],
    // Port 2 gated words, one per cell
    input  rvPkg::word_t cellQ2 [rvPkg::numRegs],
    // Combined read data
    output rvPkg::word_t rs1Data,
    output rvPkg::word_t rs2Data
);

    import rvPkg::*;

    ////////////////////////////////////////////////////////////
    // OR reduction
    ////////////////////////////////////////////////////////////

    // Folds every gated word together
    // Only the addressed cell drives nonzero bits
    function automatic word_t orAll(input word_t words [numRegs]);
        word_t acc;
        acc = '0;
        for (int k = 0; k < numRegs; k++) begin
            acc = acc | words[k];
        end
        return acc;
    endfunction

    ////////////////////////////////////////////////////////////
    // Port outputs
    ////////////////////////////////////////////////////////////

    // Read port 1
    assign rs1Data = orAll(cellQ1);

    // Read port 2
    // x0 reads as zero since its cell never loads
    assign rs2Data = orAll(cellQ2);

endmodule

// ==== hw/regWriteDecode.sv ====
`timescale 1ns/1ns

// Write index decoder for the register file
// Produces one enable per register cell
module regWriteDecode (
    // Write strobe from the core
    input  logic                       wEn,
    // Destination register number
    input  rvPkg::regIdx_t             wSel,
    // One-hot cell enables
    output logic [rvPkg::numRegs-1:0]  cellEn
);

    import rvPkg::*;

    ////////////////////////////////////////////////////////////
    // Index compare per cell
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Nothing enabled by default
        cellEn = '0;

        // Loop starts at 1 so x0 never sees an enable
        for (int k = 1; k < numRegs; k++) begin
            // At most one index can match wSel
            cellEn[k] = wEn && (wSel == regIdx_t'(k));
        end

        // x0 is hardwired to zero
        cellEn[0] = 1'b0;
    end

endmodule

// ==== hw/rvAlu.sv ====
`timescale 1ns/1ns

// RV32I integer ALU
// Purely combinational, covers the R and I type arithmetic ops
module rvAlu (
    // Operation select
    input  rvPkg::aluOp_t aluOp,
    // First operand, always rs1
    input  rvPkg::word_t  a,
    // Second operand, rs2 or immediate
    input  rvPkg::word_t  b,
    // Result
    output rvPkg::word_t  y
);

    import rvPkg::*;

    // Shift amount is the low five bits only
    logic [4:0] shamt;

    // Compare flags
    logic ltSigned;
    logic ltUnsigned;

    assign shamt = b[4:0];

    // Signed view of both operands
    assign ltSigned   = $signed(a) < $signed(b);
    // Plain magnitude compare
    assign ltUnsigned = a < b;

    ////////////////////////////////////////////////////////////
    // Result mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            // Wraps modulo 2^32
            AluAdd: y = a + b;
            AluSub: y = a - b;

            // Bitwise logic
            AluAnd: y = a & b;
            AluOr:  y = a | b;
            AluXor: y = a ^ b;

            // Left shift fills zeros
            AluSll: y = a << shamt;
            // Logical right shift fills zeros
            AluSrl: y = a >> shamt;
            // Arithmetic right shift copies the sign bit
            AluSra: y = word_t'($signed(a) >>> shamt);

            // Set less than, result is 0 or 1
            AluSlt:  y = word_t'(ltSigned);
            AluSltu: y = word_t'(ltUnsigned);

            // Unused encodings
            default: y = '0;
        endcase
    end

endmodule

// ==== hw/rvExecCore.sv ====
`timescale 1ns/1ns

// Integer execute slice
// Reads operands, runs the ALU, writes rd and reports on the writeback bus
module rvExecCore (
    input  logic            clk,
    input  logic            rst,
    // Decoded operation from the front end
    input  logic            opValid,
    input  rvPkg::execOp_t  op,
    // Registered writeback report
    output logic            wbValid,
    output rvPkg::wbBus_t   wb
);

    import rvPkg::*;

    // Register file read data
    word_t rs1Data;
    word_t rs2Data;

    // Second ALU operand after the immediate mux
    word_t operandB;

    // ALU result, also the write data
    word_t aluY;

    ////////////////////////////////////////////////////////////
    // Operand read
    ////////////////////////////////////////////////////////////

    // Write lands on the same edge the report is captured
    // Next cycle already sees the new value
    regFile regFileInst (
        .clk     (clk),
        .rst     (rst),
        .rs1     (op.rs1),
        .rs1Data (rs1Data),
        .rs2     (op.rs2),
        .rs2Data (rs2Data),
        .wEn     (opValid),
        .wSel    (op.rd),
        .wData   (aluY)
    );

    ////////////////////////////////////////////////////////////
    // Operand select and ALU
    ////////////////////////////////////////////////////////////

    // Immediate replaces rs2 for I type ops
    assign operandB = op.useImm ? op.imm : rs2Data;

    rvAlu aluInst (
        .aluOp (op.aluOp),
        .a     (rs1Data),
        .b     (operandB),
        .y     (aluY)
    );

    ////////////////////////////////////////////////////////////
    // Writeback report
    ////////////////////////////////////////////////////////////

    // One cycle after issue, valid for one cycle only
    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
            wb      <= '0;
        end else begin
            wbValid <= opValid;
            // Holds the last report while idle
            if (opValid) begin
                wb.rd   <= op.rd;
                // Reported even for rd 0, though x0 keeps zero
                wb.data <= aluY;
            end
        end
    end

endmodule

// ==== hw/rvPkg.sv ====
package rvPkg;

    ////////////////////////////////////////////////////////////
    // Machine widths
    ////////////////////////////////////////////////////////////

    // RV32I data word
    localparam int xlen = 32;

    // Architectural register count, x0 included
    localparam int numRegs = 32;

    // Bits needed to name one register
    localparam int regIdxW = $clog2(numRegs);

    ////////////////////////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////////////////////////

    // One data word
    typedef logic [xlen-1:0] word_t;

    // One register index
    typedef logic [regIdxW-1:0] regIdx_t;

    // Integer operations the execute slice understands
    // Encodings are internal and not RISC-V funct fields
    typedef enum logic [3:0] {
        AluAdd  = 4'd0,
        AluSub  = 4'd1,
        AluAnd  = 4'd2,
        AluOr   = 4'd3,
        AluXor  = 4'd4,
        AluSll  = 4'd5,
        AluSrl  = 4'd6,
        AluSra  = 4'd7,
        AluSlt  = 4'd8,
        AluSltu = 4'd9
    } aluOp_t;

    ////////////////////////////////////////////////////////////
    // Bundles between front end, core and writeback
    ////////////////////////////////////////////////////////////

    // One decoded operation from the front end
    typedef struct packed {
        aluOp_t  aluOp;
        regIdx_t rs1;
        regIdx_t rs2;
        regIdx_t rd;
        // High selects imm as second operand
        logic    useImm;
        // Sign extension already done upstream
        word_t   imm;
    } execOp_t;

    // One writeback report
    typedef struct packed {
        regIdx_t rd;
        word_t   data;
    } wbBus_t;

endpackage

// ==== verilog.f ====
hw/rvPkg.sv
hw/regWriteDecode.sv
hw/regCell.sv
hw/regReadPorts.sv
hw/regFile.sv
hw/rvAlu.sv
hw/rvExecCore.sv
bench/execCoreTb.sv
